// File: test/cpuStimulus.txt
# T name runs | P wordAddress instruction | I inputValue | E expectedOutput
# Addresses and values in hex, runs in decimal, outputs listed in emit order
# in R1, out R1, halt
T echo 1
I 1234ABCD
P 000 A8800000
P 001 B0800000
P 002 D0000000
E 1234ABCD
# R1 = 0x12345, R2 = -0x100, then add, sub, and, or into R3
T alu 1
P 000 08812345
P 001 0907FF00
P 002 19890000
P 003 B1800000
P 004 21890000
P 005 B1800000
P 006 49890000
P 007 B1800000
P 008 51890000
P 009 B1800000
P 00A B1000000
P 00B D0000000
E 00012245
E 00012445
E 00012300
E FFFFFF45
E FFFFFF00
# st and ld with base R2 = 0x400, then with R0 as zero base although R0 = 7
T memory 1
P 000 08000007
P 001 0880ABCD
P 002 09000400
P 003 10900010
P 004 01900010
P 005 B1800000
P 006 02000410
P 007 B2000000
P 008 0A87FFFF
P 009 12800420
P 00A 02100020
P 00B B2000000
P 00C D0000000
E 0000ABCD
E 0000ABCD
E FFFFFFFF
# brzr on zero R1 skips out R2, brzr on nonzero R2 falls through to out R3
T branch 1
P 000 08800000
P 001 09000055
P 002 90800004
P 003 B1000000
P 004 09800066
P 005 91000004
P 006 B1800000
P 007 D0000000
E 00000066
# in R1, add 3, out, started twice
T rerun 2
I 00000010
P 000 A8800000
P 001 09000003
P 002 19890000
P 003 B1800000
P 004 D0000000
E 00000013

// File: tb.f
+incdir+rtl
rtl/cpuPkg.sv
rtl/alu.sv
rtl/registerFile.sv
rtl/memoryUnit.sv
rtl/controlSequencer.sv
rtl/datapath.sv
rtl/cpuTop.sv
test/clockGen.sv
test/cpuTb.sv

// File: Bender.yml
package:
  name: busCpu

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/cpuPkg.sv
      - rtl/alu.sv
      - rtl/registerFile.sv
      - rtl/memoryUnit.sv
      - rtl/controlSequencer.sv
      - rtl/datapath.sv
      - rtl/cpuTop.sv
  - target: test
    files:
      - test/clockGen.sv
      - test/cpuTb.sv

// File: test/cpuTb.sv
`timescale 1ns/1ps

module cpuTb;
    import cpuPkg::*;

    localparam int outputTimeout = 500;
    localparam int haltTimeout = 500;
    localparam int quietCycles = 8;

    logic     Clock;
    logic     reset;
    logic     startStrobe;
    logic     loadStrobe;
    memAddr_t loadAddr;
    word_t    loadData;
    logic     inStrobe;
    word_t    inData;
    logic     outStrobe;
    word_t    outData;
    logic     halted;

    // Stimulus file contents, each entry tagged with its test number
    string    testNames[$];
    int       testRuns[$];
    int       progTest[$];
    memAddr_t progAddr[$];
    word_t    progData[$];
    int       inTest[$];
    word_t    inValue[$];
    int       expTest[$];
    word_t    expValue[$];

    integer seed;
    int     errorCount;
    int     testsRun;
    int     failedTests;
    bit     timedOut;

    clockGen clocks (
        .Clock(Clock)
    );

    cpuTop dut (
        .Clock      (Clock),
        .reset      (reset),
        .startStrobe(startStrobe),
        .loadStrobe (loadStrobe),
        .loadAddr   (loadAddr),
        .loadData   (loadData),
        .inStrobe   (inStrobe),
        .inData     (inData),
        .outStrobe  (outStrobe),
        .outData    (outData),
        .halted     (halted)
    );

    task automatic reportMismatch(string signalName, word_t expected, word_t actual);
        $display("FAIL time=%0t %s expected=%h actual=%h", $time, signalName, expected, actual);
        errorCount++;
    endtask

    task automatic reportProblem(string text);
        $display("ERROR time=%0t %s", $time, text);
        errorCount++;
    endtask

    task automatic readStimulus();
        int             fd;
        int             code;
        int             current;
        int             runs;
        logic [7:0]     tag;
        logic [31:0]    first;
        logic [31:0]    second;
        logic [1023:0]  restOfLine;
        string          name;
        current = -1;
        fd = $fopen("test/cpuStimulus.txt", "r");
        if (fd == 0) begin
            reportProblem("cannot open test/cpuStimulus.txt");
            return;
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, " %c", tag);
            if (code != 1) begin
                break;
            end
            case (tag)
                "#": begin
                    code = $fgets(restOfLine, fd);
                end
                "T": begin
                    code = $fscanf(fd, "%s %d", name, runs);
                    testNames.push_back(name);
                    testRuns.push_back(runs);
                    current++;
                end
                "P": begin
                    code = $fscanf(fd, "%h %h", first, second);
                    progTest.push_back(current);
                    progAddr.push_back(memAddr_t'(first));
                    progData.push_back(second);
                end
                "I": begin
                    code = $fscanf(fd, "%h", first);
                    inTest.push_back(current);
                    inValue.push_back(first);
                end
                "E": begin
                    code = $fscanf(fd, "%h", first);
                    expTest.push_back(current);
                    expValue.push_back(first);
                end
                default: begin
                    reportProblem($sformatf("unknown tag %c in stimulus file", tag));
                end
            endcase
        end
        $fclose(fd);
        if (testNames.size() == 0) begin
            reportProblem("stimulus file holds no tests");
        end
    endtask

    // Idle state after reset, nothing running and nothing emitted
    task automatic checkAfterReset();
        int errorsBefore;
        errorsBefore = errorCount;
        repeat (6) begin
            @(negedge Clock);
            if (halted !== 1'b1) begin
                reportMismatch("halted", 1, halted);
            end
            if (outStrobe !== 1'b0) begin
                reportMismatch("outStrobe", 0, outStrobe);
            end
        end
        testsRun++;
        if (errorCount == errorsBefore) begin
            $display("test 0 reset: ok");
        end else begin
            failedTests++;
            $display("test 0 reset: %0d errors", errorCount - errorsBefore);
        end
    endtask

    task automatic loadProgram(int test);
        foreach (progTest[i]) begin
            if (progTest[i] == test) begin
                @(negedge Clock);
                loadStrobe = 1'b1;
                loadAddr = progAddr[i];
                loadData = progData[i];
            end
        end
        @(negedge Clock);
        loadStrobe = 1'b0;
    endtask

    task automatic strobeInputs(int test);
        foreach (inTest[i]) begin
            if (inTest[i] == test) begin
                @(negedge Clock);
                inStrobe = 1'b1;
                inData = inValue[i];
            end
        end
        @(negedge Clock);
        inStrobe = 1'b0;
    endtask

    task automatic pulseStart();
        @(negedge Clock);
        startStrobe = 1'b1;
        @(negedge Clock);
        startStrobe = 1'b0;
        if (halted !== 1'b0) begin
            reportMismatch("halted", 0, halted);
        end
    endtask

    task automatic collectOutputs(int test);
        word_t expected[$];
        int    got;
        int    cycles;
        foreach (expTest[i]) begin
            if (expTest[i] == test) begin
                expected.push_back(expValue[i]);
            end
        end
        got = 0;
        cycles = 0;
        while (got < expected.size()) begin
            @(negedge Clock);
            cycles++;
            if (outStrobe === 1'b1) begin
                if (outData !== expected[got]) begin
                    reportMismatch("outData", expected[got], outData);
                end
                got++;
            end else if (halted === 1'b1) begin
                reportProblem($sformatf("program halted after %0d of %0d outputs",
                                        got, expected.size()));
                break;
            end else if (cycles >= outputTimeout) begin
                reportProblem($sformatf("timeout waiting for output %0d", got));
                timedOut = 1'b1;
                break;
            end
        end
    endtask

    task automatic waitForHalt();
        int cycles;
        cycles = 0;
        while (halted !== 1'b1) begin
            @(negedge Clock);
            cycles++;
            if (outStrobe === 1'b1) begin
                reportProblem($sformatf("unexpected extra output %h", outData));
            end
            if (halted !== 1'b1 && cycles >= haltTimeout) begin
                reportProblem("timeout waiting for halted");
                timedOut = 1'b1;
                break;
            end
        end
    endtask

    // Once halted the CPU stays quiet until the next start
    task automatic checkStaysHalted();
        repeat (quietCycles) begin
            @(negedge Clock);
            if (outStrobe !== 1'b0) begin
                reportMismatch("outStrobe", 0, outStrobe);
            end
            if (halted !== 1'b1) begin
                reportMismatch("halted", 1, halted);
            end
        end
    endtask

    task automatic runTest(int test);
        int errorsBefore;
        errorsBefore = errorCount;
        if (halted !== 1'b1) begin
            reportProblem("processor not stopped before program load");
        end
        loadProgram(test);
        strobeInputs(test);
        for (int run = 0; run < testRuns[test]; run++) begin
            pulseStart();
            collectOutputs(test);
            if (timedOut) begin
                break;
            end
            waitForHalt();
            if (timedOut) begin
                break;
            end
            checkStaysHalted();
        end
        testsRun++;
        if (errorCount == errorsBefore) begin
            $display("test %0d %s: ok", test + 1, testNames[test]);
        end else begin
            failedTests++;
            $display("test %0d %s: %0d errors", test + 1, testNames[test],
                     errorCount - errorsBefore);
        end
    endtask

    initial begin
        seed = 32'h8dce;
        reset = 1'b1;
        startStrobe = 1'b0;
        loadStrobe = 1'b0;
        loadAddr = '0;
        loadData = '0;
        inStrobe = 1'b0;
        inData = '0;
        errorCount = 0;
        testsRun = 0;
        failedTests = 0;
        timedOut = 1'b0;
        readStimulus();
        repeat (2) @(posedge Clock);
        @(negedge Clock);
        reset = 1'b0;
        checkAfterReset();
        for (int t = 0; t < testNames.size() && !timedOut; t++) begin
            runTest(t);
        end
        $display("tests %0d, failed %0d, errors %0d", testsRun, failedTests, errorCount);
        if (errorCount == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: test/clockGen.sv
`timescale 1ns/1ps

module clockGen #(
    parameter real periodNs = 8.0
) (
    output logic Clock
);

    initial begin
        Clock = 1'b0;
    end

    // Free running, toggles every half period
    always begin
        #(periodNs / 2.0) Clock = ~Clock;
    end

endmodule

// File: rtl/cpuTop.sv
`timescale 1ns/1ps

module cpuTop (
    input  logic             Clock,
    input  logic             reset,
    input  logic             startStrobe,
    input  logic             loadStrobe,
    input  cpuPkg::memAddr_t loadAddr,
    input  cpuPkg::word_t    loadData,
    input  logic             inStrobe,
    input  cpuPkg::word_t    inData,
    output logic             outStrobe,
    output cpuPkg::word_t    outData,
    output logic             halted
);
    import cpuPkg::*;

    ctrlWord_t ctrl;
    opcode_t   opcode;
    logic      conFlag;

    controlSequencer sequencer (
        .Clock      (Clock),
        .reset      (reset),
        .startStrobe(startStrobe),
        .opcode     (opcode),
        .conFlag    (conFlag),
        .ctrl       (ctrl),
        .halted     (halted)
    );

    datapath dataPath (
        .Clock     (Clock),
        .reset     (reset),
        .ctrl      (ctrl),
        .halted    (halted),
        .loadStrobe(loadStrobe),
        .loadAddr  (loadAddr),
        .loadData  (loadData),
        .inStrobe  (inStrobe),
        .inData    (inData),
        .opcode    (opcode),
        .conFlag   (conFlag),
        .outStrobe (outStrobe),
        .outData   (outData)
    );

endmodule

// File: rtl/datapath.sv
`timescale 1ns/1ps
`include "cpuDefines.svh"

module datapath (
    input  logic              Clock,
    input  logic              reset,
    input  cpuPkg::ctrlWord_t ctrl,
    input  logic              halted,
    input  logic              loadStrobe,
    input  cpuPkg::memAddr_t  loadAddr,
    input  cpuPkg::word_t     loadData,
    input  logic              inStrobe,
    input  cpuPkg::word_t     inData,
    output cpuPkg::opcode_t   opcode,
    output logic              conFlag,
    output logic              outStrobe,
    output cpuPkg::word_t     outData
);
    import cpuPkg::*;

    word_t bus;
    word_t pc;
    word_t ir;
    word_t yReg;
    word_t zReg;
    word_t inPort;
    word_t outPort;
    word_t constant;
    word_t regOut;
    word_t aluResult;
    word_t mdrValue;
    logic  isZero;

    assign constant = {{(`CPU_WORD_WIDTH - `CPU_CONST_MSB - 1){ir[`CPU_CONST_MSB]}},
                       ir[`CPU_CONST_MSB:0]};
    assign opcode = opcode_t'(ir[`CPU_OPCODE_MSB:`CPU_OPCODE_LSB]);

    // Single shared bus
    always_comb begin
        case (ctrl.busSource)
            srcPc: bus = pc;
            srcMdr: bus = mdrValue;
            srcZLow: bus = zReg;
            srcRegister: bus = regOut;
            srcInPort: bus = inPort;
            srcConstant: bus = constant;
            default: bus = '0;
        endcase
    end

    // PC held at zero while stopped so every start fetches from address 0
    always_ff @(posedge Clock) begin
        if (reset || halted) begin
            pc <= '0;
        end else if (ctrl.pcLoad) begin
            pc <= aluResult;
        end
    end

    always_ff @(posedge Clock) begin
        if (ctrl.irLoad) begin
            ir <= bus;
        end
        if (ctrl.yLoad) begin
            yReg <= bus;
        end
        if (ctrl.zLoad) begin
            zReg <= aluResult;
        end
        if (inStrobe) begin
            inPort <= inData;
        end
        if (ctrl.outLoad) begin
            outPort <= bus;
        end
    end

    always_ff @(posedge Clock) begin
        if (reset) begin
            outStrobe <= 1'b0;
            conFlag <= 1'b0;
        end else begin
            outStrobe <= ctrl.outLoad;
            if (ctrl.conCheck) begin
                conFlag <= isZero;
            end
        end
    end

    assign outData = outPort;

    registerFile regs (
        .Clock       (Clock),
        .reset       (reset),
        .instr       (ir),
        .gra         (ctrl.gra),
        .grb         (ctrl.grb),
        .grc         (ctrl.grc),
        .baOut       (ctrl.baOut),
        .registerLoad(ctrl.registerLoad),
        .busIn       (bus),
        .regOut      (regOut),
        .isZero      (isZero)
    );

    alu arith (
        .yValue  (yReg),
        .busValue(bus),
        .op      (ctrl.aluOp),
        .result  (aluResult)
    );

    memoryUnit memory (
        .Clock     (Clock),
        .reset     (reset),
        .marLoad   (ctrl.marLoad),
        .mdrLoad   (ctrl.mdrLoad),
        .memRead   (ctrl.memRead),
        .memWrite  (ctrl.memWrite),
        .busIn     (bus),
        .loadStrobe(loadStrobe && halted),
        .loadAddr  (loadAddr),
        .loadData  (loadData),
        .mdrValue  (mdrValue)
    );

endmodule

// File: rtl/controlSequencer.sv
`timescale 1ns/1ps

module controlSequencer (
    input  logic              Clock,
    input  logic              reset,
    input  logic              startStrobe,
    input  cpuPkg::opcode_t   opcode,
    input  logic              conFlag,
    output cpuPkg::ctrlWord_t ctrl,
    output logic              halted
);
    import cpuPkg::*;

    seqState_t state;
    seqState_t nextState;

    always_ff @(posedge Clock) begin
        if (reset) begin
            state <= stIdle;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            stIdle, stHalt: begin
                if (startStrobe) begin
                    nextState = stT0;
                end
            end
            stT0: nextState = stT1;
            stT1: nextState = stT2;
            stT2: nextState = stT3;
            stT3: begin
                case (opcode)
                    opHalt: nextState = stHalt;
                    opAdd, opSub, opAnd, opOr, opBrzr, opLd, opSt: nextState = stT4;
                    // Single step instructions and unknown codes go back to fetch
                    default: nextState = stT0;
                endcase
            end
            stT4: nextState = stT5;
            stT5: begin
                if (opcode == opLd || opcode == opSt) begin
                    nextState = stT6;
                end else begin
                    nextState = stT0;
                end
            end
            stT6: nextState = stT0;
            default: nextState = stIdle;
        endcase
    end

    // One control word per step
    always_comb begin
        ctrl = '0;
        case (state)
            stT0: begin
                ctrl.busSource = srcPc;
                ctrl.marLoad = 1'b1;
                ctrl.aluOp = aluInc4;
                ctrl.pcLoad = 1'b1;
            end
            stT1: begin
                ctrl.memRead = 1'b1;
                ctrl.mdrLoad = 1'b1;
            end
            stT2: begin
                ctrl.busSource = srcMdr;
                ctrl.irLoad = 1'b1;
            end
            stT3: begin
                case (opcode)
                    opLd: begin
                        ctrl.grb = 1'b1;
                        ctrl.baOut = 1'b1;
                        ctrl.busSource = srcRegister;
                        ctrl.yLoad = 1'b1;
                    end
                    opSt: begin
                        // Store data goes to the MDR first
                        ctrl.gra = 1'b1;
                        ctrl.busSource = srcRegister;
                        ctrl.mdrLoad = 1'b1;
                    end
                    opLdi: begin
                        ctrl.busSource = srcConstant;
                        ctrl.gra = 1'b1;
                        ctrl.registerLoad = 1'b1;
                    end
                    opAdd, opSub, opAnd, opOr: begin
                        ctrl.grb = 1'b1;
                        ctrl.busSource = srcRegister;
                        ctrl.yLoad = 1'b1;
                    end
                    opBrzr: begin
                        ctrl.gra = 1'b1;
                        ctrl.conCheck = 1'b1;
                    end
                    opIn: begin
                        ctrl.busSource = srcInPort;
                        ctrl.gra = 1'b1;
                        ctrl.registerLoad = 1'b1;
                    end
                    opOut: begin
                        ctrl.gra = 1'b1;
                        ctrl.busSource = srcRegister;
                        ctrl.outLoad = 1'b1;
                    end
                    default: begin
                        ctrl.busSource = srcNone;
                    end
                endcase
            end
            stT4: begin
                case (opcode)
                    opLd: begin
                        ctrl.busSource = srcConstant;
                        ctrl.aluOp = aluAdd;
                        ctrl.zLoad = 1'b1;
                    end
                    opSt: begin
                        ctrl.grb = 1'b1;
                        ctrl.baOut = 1'b1;
                        ctrl.busSource = srcRegister;
                        ctrl.yLoad = 1'b1;
                    end
                    opAdd, opSub, opAnd, opOr: begin
                        ctrl.grc = 1'b1;
                        ctrl.busSource = srcRegister;
                        ctrl.zLoad = 1'b1;
                        case (opcode)
                            opSub: ctrl.aluOp = aluSub;
                            opAnd: ctrl.aluOp = aluAnd;
                            opOr: ctrl.aluOp = aluOr;
                            default: ctrl.aluOp = aluAdd;
                        endcase
                    end
                    opBrzr: begin
                        // PC already points past the branch
                        ctrl.busSource = srcPc;
                        ctrl.yLoad = 1'b1;
                    end
                    default: begin
                        ctrl.busSource = srcNone;
                    end
                endcase
            end
            stT5: begin
                case (opcode)
                    opLd: begin
                        // Address goes to the MAR and the RAM in the same cycle
                        ctrl.busSource = srcZLow;
                        ctrl.marLoad = 1'b1;
                        ctrl.memRead = 1'b1;
                        ctrl.mdrLoad = 1'b1;
                    end
                    opSt: begin
                        ctrl.busSource = srcConstant;
                        ctrl.aluOp = aluAdd;
                        ctrl.zLoad = 1'b1;
                    end
                    opAdd, opSub, opAnd, opOr: begin
                        ctrl.busSource = srcZLow;
                        ctrl.gra = 1'b1;
                        ctrl.registerLoad = 1'b1;
                    end
                    opBrzr: begin
                        ctrl.busSource = srcConstant;
                        ctrl.aluOp = aluAdd;
                        ctrl.pcLoad = conFlag;
                    end
                    default: begin
                        ctrl.busSource = srcNone;
                    end
                endcase
            end
            stT6: begin
                if (opcode == opLd) begin
                    ctrl.busSource = srcMdr;
                    ctrl.gra = 1'b1;
                    ctrl.registerLoad = 1'b1;
                end else if (opcode == opSt) begin
                    ctrl.busSource = srcZLow;
                    ctrl.marLoad = 1'b1;
                    ctrl.memWrite = 1'b1;
                end
            end
            default: begin
                ctrl = '0;
            end
        endcase
    end

    assign halted = (state == stIdle) || (state == stHalt);

    // A fetched word must decode to a known opcode
    knownOpcode: assert property (@(posedge Clock) disable iff (reset)
        (state == stT3) |-> !$isunknown(opcode));

endmodule

// File: rtl/memoryUnit.sv
`timescale 1ns/1ps
`include "cpuDefines.svh"

module memoryUnit (
    input  logic            Clock,
    input  logic            reset,
    input  logic            marLoad,
    input  logic            mdrLoad,
    input  logic            memRead,
    input  logic            memWrite,
    input  cpuPkg::word_t   busIn,
    input  logic            loadStrobe,
    input  cpuPkg::memAddr_t loadAddr,
    input  cpuPkg::word_t   loadData,
    output cpuPkg::word_t   mdrValue
);
    import cpuPkg::*;

    word_t    ram [`CPU_MEM_DEPTH];
    memAddr_t mar;
    memAddr_t accessAddr;
    word_t    mdr;

    // Byte address on the bus, word index into the RAM
    // An address arriving with marLoad is used right away
    assign accessAddr = marLoad ?
        busIn[`CPU_ADDR_WIDTH + `CPU_BYTE_BITS - 1:`CPU_BYTE_BITS] : mar;

    always_ff @(posedge Clock) begin
        if (reset) begin
            mar <= '0;
        end else if (marLoad) begin
            mar <= accessAddr;
        end
    end

    always_ff @(posedge Clock) begin
        if (mdrLoad) begin
            if (memRead) begin
                mdr <= ram[accessAddr];
            end else begin
                mdr <= busIn;
            end
        end
    end

    // Program load port has priority, only used while stopped
    always_ff @(posedge Clock) begin
        if (loadStrobe) begin
            ram[loadAddr] <= loadData;
        end else if (memWrite) begin
            ram[accessAddr] <= mdr;
        end
    end

    assign mdrValue = mdr;

    noLoadWhileRunning: assert property (@(posedge Clock) disable iff (reset)
        !(loadStrobe && memWrite));

endmodule

// File: rtl/registerFile.sv
`timescale 1ns/1ps
`include "cpuDefines.svh"

module registerFile (
    input  logic          Clock,
    input  logic          reset,
    input  cpuPkg::word_t instr,
    input  logic          gra,
    input  logic          grb,
    input  logic          grc,
    input  logic          baOut,
    input  logic          registerLoad,
    input  cpuPkg::word_t busIn,
    output cpuPkg::word_t regOut,
    output logic          isZero
);
    import cpuPkg::*;

    word_t     registers [`CPU_REG_COUNT];
    regIndex_t selected;

    // Select field decode from the IR
    always_comb begin
        selected = '0;
        if (gra) begin
            selected = instr[`CPU_RA_MSB:`CPU_RA_LSB];
        end else if (grb) begin
            selected = instr[`CPU_RB_MSB:`CPU_RB_LSB];
        end else if (grc) begin
            selected = instr[`CPU_RC_MSB:`CPU_RC_LSB];
        end
    end

    // R0 acts as a zero base for ld and st
    assign regOut = (baOut && selected == '0) ? '0 : registers[selected];
    assign isZero = (regOut == '0);

    always_ff @(posedge Clock) begin
        if (reset) begin
            for (int i = 0; i < `CPU_REG_COUNT; i++) begin
                registers[i] <= '0;
            end
        end else if (registerLoad) begin
            registers[selected] <= busIn;
        end
    end

    singleSelect: assert property (@(posedge Clock) disable iff (reset)
        $onehot0({gra, grb, grc}));

endmodule

// File: rtl/alu.sv
`timescale 1ns/1ps

module alu (
    input  cpuPkg::word_t  yValue,
    input  cpuPkg::word_t  busValue,
    input  cpuPkg::aluOp_t op,
    output cpuPkg::word_t  result
);
    import cpuPkg::*;

    always_comb begin
        case (op)
            aluAdd: begin
                result = yValue + busValue;
            end
            aluSub: begin
                // Y holds the first operand
                result = yValue - busValue;
            end
            aluAnd: begin
                result = yValue & busValue;
            end
            aluOr: begin
                result = yValue | busValue;
            end
            aluInc4: begin
                // PC step, one word is four bytes
                result = busValue + word_t'(4);
            end
            default: begin
                result = busValue;
            end
        endcase
    end

endmodule

// File: rtl/cpuPkg.sv
`include "cpuDefines.svh"

package cpuPkg;

    typedef logic [`CPU_WORD_WIDTH-1:0] word_t;
    typedef logic [3:0] regIndex_t;
    typedef logic [`CPU_ADDR_WIDTH-1:0] memAddr_t;

    // Opcode encodings of the kept instructions
    typedef enum logic [4:0] {
        opLd   = 5'b00000,
        opLdi  = 5'b00001,
        opSt   = 5'b00010,
        opAdd  = 5'b00011,
        opSub  = 5'b00100,
        opAnd  = 5'b01001,
        opOr   = 5'b01010,
        opBrzr = 5'b10010,
        opIn   = 5'b10101,
        opOut  = 5'b10110,
        opHalt = 5'b11010
    } opcode_t;

    typedef enum logic [2:0] {
        srcNone,
        srcPc,
        srcMdr,
        srcZLow,
        srcRegister,
        srcInPort,
        srcConstant
    } busSource_t;

    typedef enum logic [2:0] {
        aluPass,
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluInc4
    } aluOp_t;

    // ld and st need a seventh step, so T6 follows T5
    typedef enum logic [3:0] {
        stIdle,
        stT0,
        stT1,
        stT2,
        stT3,
        stT4,
        stT5,
        stT6,
        stHalt
    } seqState_t;

    typedef struct packed {
        busSource_t busSource;
        logic       pcLoad;
        logic       marLoad;
        logic       mdrLoad;
        logic       irLoad;
        logic       yLoad;
        logic       zLoad;
        logic       registerLoad;
        logic       outLoad;
        logic       memRead;
        logic       memWrite;
        aluOp_t     aluOp;
        logic       gra;
        logic       grb;
        logic       grc;
        logic       baOut;
        logic       conCheck;
    } ctrlWord_t;

endpackage

// File: rtl/cpuDefines.svh
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// Data path and storage sizes
`define CPU_WORD_WIDTH 32
`define CPU_REG_COUNT 16
`define CPU_MEM_DEPTH 512
`define CPU_ADDR_WIDTH 9

// Addresses on the bus are byte addresses, RAM is word indexed
`define CPU_BYTE_BITS 2

// Instruction field positions
`define CPU_OPCODE_MSB 31
`define CPU_OPCODE_LSB 27
`define CPU_RA_MSB 26
`define CPU_RA_LSB 23
`define CPU_RB_MSB 22
`define CPU_RB_LSB 19
`define CPU_RC_MSB 18
`define CPU_RC_LSB 15

// Constant C occupies bits 18..0 and is sign extended
`define CPU_CONST_MSB 18

`endif
